/* hw/drs_pkg.sv */
package drs_pkg;

  // ----------------------------------------
  // chip address codes
  // ----------------------------------------

  typedef logic [3:0] chip_addr_t;

  // address values from the DRS4 datasheet
  localparam chip_addr_t ADR_READ_SR  = 4'b1011;
  localparam chip_addr_t ADR_WRITE_SR = 4'b1101;
  localparam chip_addr_t ADR_CONFIG   = 4'b1100;
  localparam chip_addr_t ADR_STANDBY  = 4'b1111;

  // ----------------------------------------
  // channels
  // ----------------------------------------

  // eight signal channels plus the reference channel
  localparam int NUM_CHANNELS = 9;

  typedef logic [3:0]              chan_t;
  typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

  // ----------------------------------------
  // readout and serial fields
  // ----------------------------------------

  localparam int STOP_CELL_BITS = 10;
  localparam int SR_WORD_BITS   = 8;

  typedef logic [9:0]                sample_count_t;
  typedef logic [STOP_CELL_BITS-1:0] stop_cell_t;
  typedef logic [5:0]                latency_t;
  typedef logic [SR_WORD_BITS-1:0]   sr_word_t;

  // config bits 7..3 are reserved and must be written as ones
  localparam sr_word_t CONFIG_RESERVED_ONES = 8'hf8;

endpackage

/* hw/drs_shift_serializer.sv */
`timescale 1ns/1ns

module drs_shift_serializer
  import drs_pkg::*;
(
  input  logic     clock,
  input  logic     reset,

  // load strobe and the word to send
  input  logic     load_i,
  input  sr_word_t word_i,

  // serial pins towards the chip
  output logic     srclk_en_o,
  output logic     srin_o,

  // high during the last bit
  output logic     done_o
);

  localparam int CNT_W = $clog2(SR_WORD_BITS);

  // ----------------------------------------
  // shift state
  // ----------------------------------------

  sr_word_t         shreg;
  logic [CNT_W-1:0] bit_cnt;
  logic             active;
  logic             last_bit;

  // last bit of the word is on the pin
  assign last_bit = active && (bit_cnt == CNT_W'(SR_WORD_BITS - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      active  <= 1'b0;
      bit_cnt <= '0;
    end else if (load_i) begin
      // first bit goes out on the next cycle
      active  <= 1'b1;
      bit_cnt <= '0;
    end else if (active) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (last_bit)
        active <= 1'b0;
    end
  end

  // msb first
  always_ff @(posedge clock) begin
    if (load_i)
      shreg <= word_i;
    else if (active)
      shreg <= {shreg[SR_WORD_BITS-2:0], 1'b0};
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  assign srclk_en_o = active;
  assign srin_o     = shreg[SR_WORD_BITS-1];
  assign done_o     = last_bit;

endmodule

/* hw/drs_channel_sequencer.sv */
`timescale 1ns/1ns

module drs_channel_sequencer
  import drs_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  // channel enables from the host
  input  logic [7:0] mask_i,

  // load at event start, advance after each channel
  input  logic       load_i,
  input  logic       advance_i,

  output chan_t      chan_o,
  output logic       last_o
);

  // ----------------------------------------
  // mask handling
  // ----------------------------------------

  chan_mask_t full_mask;
  chan_mask_t pending;
  chan_t      cur_chan;
  logic       no_higher;

  // reference channel rides along whenever anything is enabled
  assign full_mask = {(|mask_i), mask_i};

  // lowest pending channel
  always_comb begin
    cur_chan = '0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      if (pending[i])
        cur_chan = chan_t'(i);
    end
  end

  // any pending bit above the current one
  always_comb begin
    no_higher = 1'b1;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (pending[i] && (chan_t'(i) > cur_chan))
        no_higher = 1'b0;
    end
  end

  // ----------------------------------------
  // pending channel register
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
    end else if (load_i) begin
      pending <= full_mask;
    end else if (advance_i) begin
      // drop the channel just read
      pending[cur_chan] <= 1'b0;
    end
  end

  assign chan_o = cur_chan;
  assign last_o = no_higher;

endmodule

/* hw/drs_readout_datapath.sv */
`timescale 1ns/1ns

module drs_readout_datapath
  import drs_pkg::*;
#(
  parameter int ADC_WIDTH = 14
) (
  input  logic                 clock,
  input  logic                 reset,

  // readout window and first channel flag from the fsm
  input  logic                 active_i,
  input  logic                 first_chan_i,

  // chip serial output carries the stop cell
  input  logic                 srout_i,

  input  sample_count_t        samples_i,
  input  latency_t             adc_latency_i,
  input  logic [ADC_WIDTH-1:0] adc_data_i,

  output logic                 srclk_en_o,
  output logic                 chan_done_o,
  output logic                 fifo_wen_o,
  output logic [ADC_WIDTH-1:0] fifo_wdata_o,
  output stop_cell_t           stop_cell_o
);

  localparam int CYC_W = 11;
  localparam int SC_W  = $clog2(STOP_CELL_BITS + 1);

  // ----------------------------------------
  // adc capture
  // ----------------------------------------

  logic [ADC_WIDTH-1:0] adc_neg;
  logic [ADC_WIDTH-1:0] adc_q;

  // adc and fpga share the clock so sample in the middle of the bit
  always_ff @(negedge clock) begin
    adc_neg <= adc_data_i;
  end

  // back onto the rising edge
  always_ff @(posedge clock) begin
    adc_q <= adc_neg;
  end

  // ----------------------------------------
  // per channel counters
  // ----------------------------------------

  logic [CYC_W-1:0] cyc;
  sample_count_t    wr_cnt;
  logic             wr_en;
  logic             last_wr;
  logic [SC_W-1:0]  sc_cnt;
  stop_cell_t       sc_shift;
  logic             active_q;

  // samples_i + 1 shift clocks per channel
  assign srclk_en_o = active_i && (cyc <= CYC_W'(samples_i));

  // skip the adc pipeline then write samples_i words
  assign wr_en   = active_i && (cyc > CYC_W'(adc_latency_i)) && (wr_cnt != samples_i);
  assign last_wr = wr_en && (wr_cnt == samples_i - 1'b1);

  always_ff @(posedge clock) begin
    if (reset) begin
      cyc         <= '0;
      wr_cnt      <= '0;
      fifo_wen_o  <= 1'b0;
      chan_done_o <= 1'b0;
      sc_cnt      <= '0;
      active_q    <= 1'b0;
      stop_cell_o <= '0;
    end else begin
      fifo_wen_o  <= wr_en;
      chan_done_o <= last_wr;
      active_q    <= active_i;

      // restart for the next channel
      if (!active_i || chan_done_o) begin
        cyc    <= '0;
        wr_cnt <= '0;
      end else begin
        cyc <= cyc + 1'b1;
        if (wr_en)
          wr_cnt <= wr_cnt + 1'b1;
      end

      // stop cell comes out msb first on the first clocks of the event
      if (!active_i)
        sc_cnt <= '0;
      else if (first_chan_i && srclk_en_o && (sc_cnt != SC_W'(STOP_CELL_BITS))) begin
        sc_shift <= {sc_shift[STOP_CELL_BITS-2:0], srout_i};
        sc_cnt   <= sc_cnt + 1'b1;
      end

      // publish once the readout window closes
      if (active_q && !active_i)
        stop_cell_o <= sc_shift;
    end
  end

  // ----------------------------------------
  // fifo data
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (wr_en)
      fifo_wdata_o <= adc_q;
  end

endmodule

/* hw/drs_control_fsm.sv */
`timescale 1ns/1ns

module drs_control_fsm
  import drs_pkg::*;
#(
  parameter int DOMINO_SETTLE_CYCLES = 105
) (
  input  logic       clock,
  input  logic       reset,

  // host strobes and levels
  input  logic       start_i,
  input  logic       reinit_i,
  input  logic       configure_i,
  input  logic       trigger_i,
  input  logic       dmode_i,
  input  sr_word_t   config_i,
  input  sr_word_t   chn_config_i,
  input  logic [7:0] mask_i,

  // from sequencer, serializer and datapath
  input  chan_t      chan_i,
  input  logic       chan_last_i,
  input  logic       chan_done_i,
  input  logic       ser_srclk_i,
  input  logic       ser_srin_i,
  input  logic       ser_done_i,
  input  logic       rdo_srclk_i,

  output logic       ser_load_o,
  output sr_word_t   ser_word_o,
  output logic       seq_load_o,
  output logic       rdo_active_o,
  output logic       first_chan_o,

  // chip pins and status
  output chip_addr_t addr_o,
  output logic       nreset_o,
  output logic       denable_o,
  output logic       dwrite_o,
  output logic       rsrload_o,
  output logic       srclk_en_o,
  output logic       srin_o,
  output logic       busy_o,
  output logic       readout_complete_o
);

  localparam int SETTLE_W = $clog2(DOMINO_SETTLE_CYCLES + 2);

  typedef enum logic [3:0] {
    INIT, IDLE, CONF_WRITE, WSR_WRITE, START_RUNNING, RUNNING,
    TRIGGER, RSR_ADDR, RSR_LOAD, ADC_READOUT, STOP_CELL, DONE
  } state_t;

  state_t              state;
  logic [SETTLE_W-1:0] settle_cnt;
  logic                init_cnt;
  logic                reinit_req;
  logic                dwrite_req;
  chip_addr_t          addr_q;
  logic                in_conf;
  logic                abort;
  logic                trig_ok;
  logic                rdo_addr_sel;

  // ----------------------------------------
  // decodes and pin muxes
  // ----------------------------------------

  // configure runs to completion
  assign in_conf = (state == CONF_WRITE) || (state == WSR_WRITE);
  assign abort   = reinit_req && !in_conf && (state != INIT);

  // trigger counts only with something to read
  assign trig_ok = trigger_i && (|mask_i);

  // second load lands on the done cycle so both words run back to back
  assign ser_load_o = ((state == IDLE) && configure_i && !reinit_req) ||
                      ((state == CONF_WRITE) && ser_done_i);
  assign ser_word_o = (state == IDLE) ? (config_i | CONFIG_RESERVED_ONES) : chn_config_i;

  assign seq_load_o   = (state == TRIGGER);
  assign rdo_active_o = (state == ADC_READOUT);
  assign rsrload_o    = (state == RSR_LOAD);

  // channel number is the chip address during readout
  assign rdo_addr_sel = (state == RSR_ADDR) || (state == RSR_LOAD) || (state == ADC_READOUT);
  assign addr_o       = rdo_addr_sel ? chip_addr_t'(chan_i) : addr_q;

  assign srclk_en_o = ser_srclk_i | rdo_srclk_i;
  assign srin_o     = ser_srclk_i & ser_srin_i;

  // ----------------------------------------
  // state machine
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state              <= INIT;
      settle_cnt         <= '0;
      init_cnt           <= 1'b0;
      reinit_req         <= 1'b0;
      dwrite_req         <= 1'b0;
      addr_q             <= ADR_STANDBY;
      nreset_o           <= 1'b0;
      denable_o          <= 1'b0;
      dwrite_o           <= 1'b0;
      first_chan_o       <= 1'b0;
      busy_o             <= 1'b0;
      readout_complete_o <= 1'b0;
    end else begin
      dwrite_o           <= dwrite_req;
      readout_complete_o <= 1'b0;

      // reinit strobe is one cycle wide so keep it
      if (state == INIT)
        reinit_req <= reinit_i;
      else
        reinit_req <= reinit_req | reinit_i;

      if (abort) begin
        // chip reset starts on entry
        state        <= INIT;
        init_cnt     <= 1'b0;
        nreset_o     <= 1'b0;
        denable_o    <= 1'b0;
        dwrite_req   <= 1'b0;
        first_chan_o <= 1'b0;
        busy_o       <= 1'b0;
      end else begin
        case (state)
          INIT: begin
            // two cycles of nreset low per datasheet
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt) begin
              state    <= IDLE;
              nreset_o <= 1'b1;
              addr_q   <= ADR_READ_SR;
            end
          end
          IDLE: begin
            nreset_o   <= 1'b1;
            addr_q     <= ADR_READ_SR;
            settle_cnt <= '0;
            if (configure_i) begin
              state  <= CONF_WRITE;
              addr_q <= ADR_CONFIG;
            end else if (start_i) begin
              state      <= START_RUNNING;
              busy_o     <= 1'b1;
              denable_o  <= 1'b1;
              dwrite_req <= 1'b1;
            end
          end
          CONF_WRITE: begin
            if (ser_done_i) begin
              state  <= WSR_WRITE;
              addr_q <= ADR_WRITE_SR;
            end
          end
          WSR_WRITE: begin
            if (ser_done_i) begin
              state  <= IDLE;
              addr_q <= ADR_READ_SR;
            end
          end
          START_RUNNING: begin
            // let the domino wave go round before arming
            settle_cnt <= settle_cnt + 1'b1;
            if (settle_cnt == SETTLE_W'(DOMINO_SETTLE_CYCLES))
              state <= RUNNING;
          end
          RUNNING: begin
            // single shot goes straight to readout
            if (!dmode_i || trig_ok) begin
              state      <= TRIGGER;
              dwrite_req <= 1'b0;
            end
          end
          TRIGGER: begin
            state        <= RSR_ADDR;
            first_chan_o <= 1'b1;
          end
          // address setup before rsrload
          RSR_ADDR: state <= RSR_LOAD;
          RSR_LOAD: state <= ADC_READOUT;
          ADC_READOUT: begin
            if (chan_done_i) begin
              first_chan_o <= 1'b0;
              if (chan_last_i)
                state <= STOP_CELL;
            end
          end
          STOP_CELL: begin
            state              <= DONE;
            readout_complete_o <= 1'b1;
          end
          DONE: begin
            // keep the chip writing between events
            state      <= IDLE;
            busy_o     <= 1'b0;
            dwrite_req <= 1'b1;
          end
          default: state <= INIT;
        endcase
      end
    end
  end

endmodule

/* hw/drs_top.sv */
`timescale 1ns/1ns

module drs_top
  import drs_pkg::*;
#(
  parameter int ADC_WIDTH            = 14,
  parameter int DOMINO_SETTLE_CYCLES = 105
) (
  input  logic                 clock,
  input  logic                 reset,

  // host control
  input  logic                 dmode_i,
  input  sample_count_t        samples_i,
  input  latency_t             adc_latency_i,
  input  sr_word_t             config_i,
  input  sr_word_t             chn_config_i,
  input  logic [7:0]           readout_mask_i,
  input  logic                 start_i,
  input  logic                 reinit_i,
  input  logic                 configure_i,
  input  logic                 trigger_i,

  // DRS4 pins
  input  logic                 srout_i,
  output chip_addr_t           addr_o,
  output logic                 nreset_o,
  output logic                 denable_o,
  output logic                 dwrite_o,
  output logic                 rsrload_o,
  output logic                 srclk_en_o,
  output logic                 srin_o,

  // adc in and fifo out
  input  logic [ADC_WIDTH-1:0] adc_data_i,
  output logic [ADC_WIDTH-1:0] fifo_wdata_o,
  output logic                 fifo_wen_o,

  // status
  output stop_cell_t           stop_cell_o,
  output logic                 busy_o,
  output logic                 readout_complete_o
);

  // ----------------------------------------
  // internal wiring
  // ----------------------------------------

  logic     ser_load;
  sr_word_t ser_word;
  logic     ser_srclk;
  logic     ser_srin;
  logic     ser_done;
  logic     seq_load;
  chan_t    chan;
  logic     chan_last;
  logic     chan_done;
  logic     rdo_active;
  logic     first_chan;
  logic     rdo_srclk;

  drs_control_fsm #(
    .DOMINO_SETTLE_CYCLES(DOMINO_SETTLE_CYCLES)
  ) fsm_i (
    .clock              (clock),
    .reset              (reset),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .trigger_i          (trigger_i),
    .dmode_i            (dmode_i),
    .config_i           (config_i),
    .chn_config_i       (chn_config_i),
    .mask_i             (readout_mask_i),
    .chan_i             (chan),
    .chan_last_i        (chan_last),
    .chan_done_i        (chan_done),
    .ser_srclk_i        (ser_srclk),
    .ser_srin_i         (ser_srin),
    .ser_done_i         (ser_done),
    .rdo_srclk_i        (rdo_srclk),
    .ser_load_o         (ser_load),
    .ser_word_o         (ser_word),
    .seq_load_o         (seq_load),
    .rdo_active_o       (rdo_active),
    .first_chan_o       (first_chan),
    .addr_o             (addr_o),
    .nreset_o           (nreset_o),
    .denable_o          (denable_o),
    .dwrite_o           (dwrite_o),
    .rsrload_o          (rsrload_o),
    .srclk_en_o         (srclk_en_o),
    .srin_o             (srin_o),
    .busy_o             (busy_o),
    .readout_complete_o (readout_complete_o)
  );

  // config and write shift register loads
  drs_shift_serializer ser_i (
    .clock      (clock),
    .reset      (reset),
    .load_i     (ser_load),
    .word_i     (ser_word),
    .srclk_en_o (ser_srclk),
    .srin_o     (ser_srin),
    .done_o     (ser_done)
  );

  drs_channel_sequencer seq_i (
    .clock     (clock),
    .reset     (reset),
    .mask_i    (readout_mask_i),
    .load_i    (seq_load),
    .advance_i (chan_done),
    .chan_o    (chan),
    .last_o    (chan_last)
  );

  drs_readout_datapath #(
    .ADC_WIDTH(ADC_WIDTH)
  ) rdo_i (
    .clock         (clock),
    .reset         (reset),
    .active_i      (rdo_active),
    .first_chan_i  (first_chan),
    .srout_i       (srout_i),
    .samples_i     (samples_i),
    .adc_latency_i (adc_latency_i),
    .adc_data_i    (adc_data_i),
    .srclk_en_o    (rdo_srclk),
    .chan_done_o   (chan_done),
    .fifo_wen_o    (fifo_wen_o),
    .fifo_wdata_o  (fifo_wdata_o),
    .stop_cell_o   (stop_cell_o)
  );

endmodule

/* testbench/tb_drs_top.sv */
`timescale 1ns/1ns

module tb_drs_top
  import drs_pkg::*;
();

  localparam int ADC_W     = 14;
  localparam int SETTLE    = 10;
  localparam int NUM_TESTS = 5;

  // one row per test
  typedef struct packed {
    logic          reinit_case;
    logic          dmode;
    logic [7:0]    mask;
    sample_count_t samples;
    latency_t      latency;
    stop_cell_t    stop_cell;
    sr_word_t      cfg;
    sr_word_t      chn_cfg;
  } test_row_t;

  test_row_t tests [NUM_TESTS];

  logic             clock;
  logic             reset;
  logic             dmode_i;
  sample_count_t    samples_i;
  latency_t         adc_latency_i;
  sr_word_t         config_i;
  sr_word_t         chn_config_i;
  logic [7:0]       readout_mask_i;
  logic             start_i;
  logic             reinit_i;
  logic             configure_i;
  logic             trigger_i;
  logic             srout_i;
  chip_addr_t       addr_o;
  logic             nreset_o;
  logic             denable_o;
  logic             dwrite_o;
  logic             rsrload_o;
  logic             srclk_en_o;
  logic             srin_o;
  logic [ADC_W-1:0] adc_data_i;
  logic [ADC_W-1:0] fifo_wdata_o;
  logic             fifo_wen_o;
  stop_cell_t       stop_cell_o;
  logic             busy_o;
  logic             readout_complete_o;

  // monitor state
  sr_word_t         conf_bits;
  sr_word_t         wsr_bits;
  int               conf_cnt;
  int               wsr_cnt;
  int               word_cnt;
  int               done_cnt;
  int               rsrload_cnt;
  chip_addr_t       last_addr;
  logic [ADC_W-1:0] last_word;
  logic [ADC_W-1:0] step;
  chan_t            chan_seen[$];

  // chip model and bookkeeping
  stop_cell_t       model_cell;
  int               model_pos;
  int               test_errs;
  int               pass_tests;
  int               fail_tests;
  int               cycle_cnt;
  int               cycle_limit;
  string            waiting_for;

  drs_top #(
    .ADC_WIDTH            (ADC_W),
    .DOMINO_SETTLE_CYCLES (SETTLE)
  ) dut_i (
    .clock              (clock),
    .reset              (reset),
    .dmode_i            (dmode_i),
    .samples_i          (samples_i),
    .adc_latency_i      (adc_latency_i),
    .config_i           (config_i),
    .chn_config_i       (chn_config_i),
    .readout_mask_i     (readout_mask_i),
    .start_i            (start_i),
    .reinit_i           (reinit_i),
    .configure_i        (configure_i),
    .trigger_i          (trigger_i),
    .srout_i            (srout_i),
    .addr_o             (addr_o),
    .nreset_o           (nreset_o),
    .denable_o          (denable_o),
    .dwrite_o           (dwrite_o),
    .rsrload_o          (rsrload_o),
    .srclk_en_o         (srclk_en_o),
    .srin_o             (srin_o),
    .adc_data_i         (adc_data_i),
    .fifo_wdata_o       (fifo_wdata_o),
    .fifo_wen_o         (fifo_wen_o),
    .stop_cell_o        (stop_cell_o),
    .busy_o             (busy_o),
    .readout_complete_o (readout_complete_o)
  );

  // ----------------------------------------
  // clock, adc source, chip model
  // ----------------------------------------

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // free running adc counter
  always @(posedge clock) begin
    adc_data_i <= adc_data_i + 1'b1;
  end

  // stop cell leaves the chip msb first after rsrload
  always @(posedge clock) begin
    if (rsrload_o) begin
      srout_i   <= model_cell[STOP_CELL_BITS-1];
      model_pos <= 1;
    end else if (srclk_en_o) begin
      if (model_pos < STOP_CELL_BITS)
        srout_i <= model_cell[STOP_CELL_BITS-1-model_pos];
      else
        srout_i <= 1'b0;
      model_pos <= model_pos + 1;
    end
  end

  // ----------------------------------------
  // monitor, mid cycle
  // ----------------------------------------

  always @(negedge clock) begin
    if (!reset) begin
      // serial words, split by address
      if (srclk_en_o && addr_o == ADR_CONFIG) begin
        conf_bits = {conf_bits[6:0], srin_o};
        conf_cnt++;
      end
      if (srclk_en_o && addr_o == ADR_WRITE_SR) begin
        wsr_bits = {wsr_bits[6:0], srin_o};
        wsr_cnt++;
      end
      if (fifo_wen_o) begin
        // new address means a new channel
        if (word_cnt == 0 || addr_o != last_addr) begin
          chan_seen.push_back(chan_t'(addr_o));
        end else begin
          // must move forward, modulo the adc width
          step = fifo_wdata_o - last_word;
          if (step == '0 || step[ADC_W-1]) begin
            $display("FAIL fifo_wdata_o: %h does not follow %h", fifo_wdata_o, last_word);
            test_errs++;
          end
        end
        // chip writing stops for the readout
        if (dwrite_o !== 1'b0) begin
          $display("FAIL dwrite_o: %h during readout, expected 0", dwrite_o);
          test_errs++;
        end
        last_addr = addr_o;
        last_word = fifo_wdata_o;
        word_cnt++;
      end
      if (readout_complete_o)
        done_cnt++;
      if (rsrload_o)
        rsrload_cnt++;
    end
  end

  // run limit from the table
  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles waiting for %s", cycle_cnt, waiting_for);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %s: got %h expected %h", name, got, exp);
    test_errs++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    test_errs++;
  endtask

  // only called on a rising edge, away from the monitor
  task automatic clear_counts();
    conf_bits   = '0;
    wsr_bits    = '0;
    conf_cnt    = 0;
    wsr_cnt     = 0;
    word_cnt    = 0;
    done_cnt    = 0;
    rsrload_cnt = 0;
    chan_seen.delete();
  endtask

  // pre-edge values are the settled ones
  task automatic wait_idle();
    waiting_for = "idle";
    @(posedge clock);
    while (!(nreset_o && !busy_o && addr_o == ADR_READ_SR))
      @(posedge clock);
  endtask

  task automatic run_configure(input test_row_t row);
    wait_idle();
    clear_counts();
    config_i     <= row.cfg;
    chn_config_i <= row.chn_cfg;
    configure_i  <= 1'b1;
    @(posedge clock);
    configure_i  <= 1'b0;
    waiting_for = "write shift register load";
    while (wsr_cnt < SR_WORD_BITS)
      @(posedge clock);
    repeat (2) @(posedge clock);
    if (conf_cnt != SR_WORD_BITS || wsr_cnt != SR_WORD_BITS)
      report_problem("serial loads did not carry 8 bits each");
    // reserved bits forced high
    if (conf_bits != (row.cfg | 8'hf8))
      report_mismatch("srin_o under ADR_CONFIG", conf_bits, row.cfg | 8'hf8);
    if (wsr_bits != row.chn_cfg)
      report_mismatch("srin_o under ADR_WRITE_SR", wsr_bits, row.chn_cfg);
  endtask

  task automatic start_event(input test_row_t row);
    wait_idle();
    clear_counts();
    model_cell     <= row.stop_cell;
    dmode_i        <= row.dmode;
    readout_mask_i <= row.mask;
    samples_i      <= row.samples;
    adc_latency_i  <= row.latency;
    start_i        <= 1'b1;
    @(posedge clock);
    start_i        <= 1'b0;
    // domino on at once, write pin one cycle behind
    repeat (2) @(posedge clock);
    if (denable_o !== 1'b1)
      report_mismatch("denable_o", denable_o, 1);
    if (dwrite_o !== 1'b1)
      report_mismatch("dwrite_o", dwrite_o, 1);
  endtask

  task automatic run_readout(input test_row_t row);
    int    exp_words;
    chan_t exp_chans[$];
    // enabled channels ascending, reference last
    for (int b = 0; b < 8; b++) begin
      if (row.mask[b])
        exp_chans.push_back(chan_t'(b));
    end
    exp_chans.push_back(chan_t'(8));
    exp_words = exp_chans.size() * row.samples;
    start_event(row);
    if (row.dmode) begin
      // settle time plus margin, then arm
      repeat (SETTLE + 20) @(posedge clock);
      if (word_cnt != 0 || rsrload_cnt != 0)
        report_problem("readout started before trigger_i");
      trigger_i <= 1'b1;
      waiting_for = "rsrload_o after trigger_i";
      while (rsrload_cnt == 0)
        @(posedge clock);
      trigger_i <= 1'b0;
    end
    waiting_for = "readout_complete_o";
    while (done_cnt == 0)
      @(posedge clock);
    repeat (3) @(posedge clock);
    if (done_cnt != 1)
      report_problem("readout_complete_o did not pulse exactly once");
    if (rsrload_cnt != 1)
      report_problem("rsrload_o did not pulse exactly once");
    if (busy_o !== 1'b0)
      report_mismatch("busy_o", busy_o, 0);
    // write request is back for the next event
    if (dwrite_o !== 1'b1)
      report_mismatch("dwrite_o", dwrite_o, 1);
    if (word_cnt != exp_words)
      report_mismatch("fifo_wen_o count", word_cnt, exp_words);
    if (chan_seen.size() != exp_chans.size()) begin
      report_mismatch("addr_o channel count", chan_seen.size(), exp_chans.size());
    end else begin
      for (int n = 0; n < exp_chans.size(); n++) begin
        if (chan_seen[n] != exp_chans[n])
          report_mismatch("addr_o", chan_seen[n], exp_chans[n]);
      end
    end
    if (stop_cell_o !== row.stop_cell)
      report_mismatch("stop_cell_o", stop_cell_o, row.stop_cell);
  endtask

  task automatic run_reinit(input test_row_t row);
    start_event(row);
    repeat (SETTLE + 20) @(posedge clock);
    // empty mask, trigger must be ignored
    trigger_i <= 1'b1;
    repeat (4) @(posedge clock);
    trigger_i <= 1'b0;
    repeat (4) @(posedge clock);
    if (rsrload_cnt != 0 || word_cnt != 0)
      report_problem("trigger with an empty mask started a readout");
    if (busy_o !== 1'b1)
      report_mismatch("busy_o", busy_o, 1);
    reinit_i <= 1'b1;
    @(posedge clock);
    reinit_i <= 1'b0;
    waiting_for = "nreset_o low after reinit_i";
    while (nreset_o !== 1'b0)
      @(posedge clock);
    waiting_for = "idle after reinit_i";
    while (nreset_o !== 1'b1)
      @(posedge clock);
    if (busy_o !== 1'b0)
      report_mismatch("busy_o", busy_o, 0);
    if (addr_o !== ADR_READ_SR)
      report_mismatch("addr_o", addr_o, ADR_READ_SR);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin : main_seq
    int t;
    // reinit, dmode, mask, samples, latency, stop cell, config, chn config
    tests[0] = '{1'b0, 1'b0, 8'h01, 10'd16, 6'd2, 10'h2a5, 8'h05, 8'hc3};
    tests[1] = '{1'b0, 1'b0, 8'ha5, 10'd12, 6'd0, 10'h1f0, 8'h02, 8'h5a};
    tests[2] = '{1'b0, 1'b1, 8'h18, 10'd20, 6'd5, 10'h33c, 8'h07, 8'hff};
    tests[3] = '{1'b0, 1'b1, 8'hff, 10'd10, 6'd9, 10'h001, 8'h00, 8'h3c};
    tests[4] = '{1'b1, 1'b1, 8'h00, 10'd16, 6'd2, 10'h000, 8'h01, 8'h81};
    cycle_limit = 400;
    for (t = 0; t < NUM_TESTS; t++)
      cycle_limit += 9 * (tests[t].samples + 64);
    cycle_cnt      = 0;
    waiting_for    = "reset";
    // every dut input defined at time zero
    reset          = 1'b1;
    dmode_i        = 1'b0;
    samples_i      = '0;
    adc_latency_i  = '0;
    config_i       = '0;
    chn_config_i   = '0;
    readout_mask_i = '0;
    start_i        = 1'b0;
    reinit_i       = 1'b0;
    configure_i    = 1'b0;
    trigger_i      = 1'b0;
    srout_i        = 1'b0;
    adc_data_i     = '0;
    model_cell     = '0;
    model_pos      = 0;
    last_addr      = '0;
    last_word      = '0;
    step           = '0;
    test_errs      = 0;
    pass_tests     = 0;
    fail_tests     = 0;
    clear_counts();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (t = 0; t < NUM_TESTS; t++) begin
      test_errs = 0;
      run_configure(tests[t]);
      if (tests[t].reinit_case)
        run_reinit(tests[t]);
      else
        run_readout(tests[t]);
      if (test_errs == 0) begin
        pass_tests++;
        $display("test %0d: ok", t);
      end else begin
        fail_tests++;
        $display("test %0d: %0d errors", t, test_errs);
      end
    end
    $display("summary: %0d tests ok, %0d tests with errors", pass_tests, fail_tests);
    if (fail_tests == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* compile.f */
hw/drs_pkg.sv
hw/drs_shift_serializer.sv
hw/drs_channel_sequencer.sv
hw/drs_readout_datapath.sv
hw/drs_control_fsm.sv
hw/drs_top.sv
testbench/tb_drs_top.sv
